// File: rv32m_pkg.sv
/*
 * Shared definitions for the RV32M execution block.
 * Holds the word width, the M-extension operation codes and the operand sign modes.
 * Compile this package before any RTL file that imports it.
 */
package rv32m_pkg;

  // Width of one integer register.
  localparam int WORD_W = 32;

  // M-extension operations, encoded in funct3 order.
  // Bit 2 set marks the divide family.
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011,
    DIV    = 3'b100,
    DIVU   = 3'b101,
    REM    = 3'b110,
    REMU   = 3'b111
  } mext_op_t;

  // Extension of the two multiplier operands.
  // First name is the multiplicand, second name the multiplier.
  typedef enum logic [1:0] {
    SIGNED          = 2'b00,
    UNSIGNED        = 2'b01,
    SIGNED_UNSIGNED = 2'b10,
    UNSIGNED_SIGNED = 2'b11
  } sign_type_t;

  // True for DIV, DIVU, REM and REMU.
  function automatic logic is_div_op(input mext_op_t op);
    return op[2];
  endfunction

  // Sign mode of a multiply, with MULHSU already reordered signed-first.
  function automatic sign_type_t mul_sign_mode(input mext_op_t op);
    case (op)
      MULHSU:  return SIGNED_UNSIGNED;
      MULHU:   return UNSIGNED;
      default: return SIGNED;
    endcase
  endfunction

endpackage

// File: multiplier.sv
/*
 * Pipelined 33x33 signed multiplier with a configurable stage count.
 * Operands are extended to 33 bits by the sign mode and the 64-bit product leaves after
 * MUL_STAGES edges. A new operand pair can enter on every cycle.
 */
`timescale 1ns/10ps

module multiplier #(
  parameter int MUL_STAGES = 3
) (
  input  logic                                CLK, nRST,
  input  logic                                start,
  input  logic [rv32m_pkg::WORD_W-1:0]        multiplicand,
  input  logic [rv32m_pkg::WORD_W-1:0]        multiplier,
  input  rv32m_pkg::sign_type_t               is_signed,
  output logic                                finished,
  output logic [2*rv32m_pkg::WORD_W-1:0]      product
);

  import rv32m_pkg::*;

  logic               sign_a, sign_b;
  logic signed [32:0] op_a, op_b;
  logic signed [49:0] pp_lo_q, pp_hi_q;
  logic signed [65:0] sum;
  logic signed [65:0] product_full;
  logic [MUL_STAGES-1:0] vld_q;

  // Extend each operand by one bit according to the sign mode.
  assign sign_a = (is_signed == SIGNED) || (is_signed == SIGNED_UNSIGNED);
  assign sign_b = (is_signed == SIGNED) || (is_signed == UNSIGNED_SIGNED);
  assign op_a   = {sign_a & multiplicand[WORD_W-1], multiplicand};
  assign op_b   = {sign_b & multiplier[WORD_W-1], multiplier};

  // First stage.
  // Split the multiplier into a signed upper 17 bits and an unsigned lower 16 bits.
  always_ff @(posedge CLK) begin
    if (start) begin
      pp_lo_q <= op_a * $signed({1'b0, op_b[15:0]});
      pp_hi_q <= op_a * $signed(op_b[32:16]);
    end
  end

  // Recombine the two partial products.
  assign sum = {pp_hi_q, 16'b0} + {{16{pp_lo_q[49]}}, pp_lo_q};

  // Remaining stages only carry the summed product.
  generate
    if (MUL_STAGES == 1) begin : g_single
      assign product_full = sum;
    end else begin : g_multi
      logic signed [65:0] prod_q [MUL_STAGES-1];
      always_ff @(posedge CLK) begin
        prod_q[0] <= sum;
        for (int k = 1; k < MUL_STAGES - 1; k++) begin
          prod_q[k] <= prod_q[k-1];
        end
      end
      assign product_full = prod_q[MUL_STAGES-2];
    end
  endgenerate

  // Valid bit travels with each product.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= start;
      for (int k = 1; k < MUL_STAGES; k++) begin
        vld_q[k] <= vld_q[k-1];
      end
    end
  end

  assign finished = vld_q[MUL_STAGES-1];
  assign product  = product_full[2*WORD_W-1:0];

endmodule

// File: multiply_unit.sv
/*
 * Multiply unit for MUL, MULH, MULHSU and MULHU.
 * Registers the operands, runs the pipelined multiplier and holds the chosen half
 * with its tag until the writeback arbiter grants it.
 */
`timescale 1ns/10ps

module multiply_unit #(
  parameter int TAG_W      = 5,
  parameter int MUL_STAGES = 3
) (
  input  logic                          CLK, nRST,
  input  logic                          start,
  input  rv32m_pkg::mext_op_t           op,
  input  logic [rv32m_pkg::WORD_W-1:0]  rs1_data,
  input  logic [rv32m_pkg::WORD_W-1:0]  rs2_data,
  input  logic [TAG_W-1:0]              tag,
  input  logic                          grant,
  output logic                          busy,
  output logic                          done,
  output logic [rv32m_pkg::WORD_W-1:0]  wdata,
  output logic [TAG_W-1:0]              wtag
);

  import rv32m_pkg::*;

  logic [WORD_W-1:0]   mcand_q, mplier_q;
  sign_type_t          sign_q;
  logic                high_sel_q;
  logic                start_q;
  logic                mul_finished;
  logic [2*WORD_W-1:0] product;

  multiplier #(
    .MUL_STAGES(MUL_STAGES)
  ) u_multiplier (
    .CLK(CLK),
    .nRST(nRST),
    .start(start_q),
    .multiplicand(mcand_q),
    .multiplier(mplier_q),
    .is_signed(sign_q),
    .finished(mul_finished),
    .product(product)
  );

  // Operand capture on accept.
  // MULHSU puts signed rs1 in the multiplicand slot.
  always_ff @(posedge CLK) begin
    if (start) begin
      mcand_q    <= (op == MULHSU) ? rs1_data : rs2_data;
      mplier_q   <= (op == MULHSU) ? rs2_data : rs1_data;
      sign_q     <= mul_sign_mode(op);
      high_sel_q <= (op != MUL);
      wtag       <= tag;
    end
  end

  // Busy from accept to grant; done from capture to grant.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      start_q <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
    end else begin
      start_q <= start;
      if (start) begin
        busy <= 1'b1;
      end else if (grant) begin
        busy <= 1'b0;
      end
      if (mul_finished) begin
        done <= 1'b1;
      end else if (grant) begin
        done <= 1'b0;
      end
    end
  end

  // Result register, one edge after the last pipeline stage.
  always_ff @(posedge CLK) begin
    if (mul_finished) begin
      wdata <= high_sel_q ? product[2*WORD_W-1:WORD_W] : product[WORD_W-1:0];
    end
  end

endmodule

// File: divider.sv
/*
 * Radix-2 restoring divider on unsigned magnitudes.
 * A start pulse loads the operands, then one quotient bit is formed per cycle.
 * finished pulses for one cycle once quotient and remainder are final.
 */
`timescale 1ns/10ps

module divider (
  input  logic                          CLK, nRST,
  input  logic                          start,
  input  logic [rv32m_pkg::WORD_W-1:0]  dividend,
  input  logic [rv32m_pkg::WORD_W-1:0]  divisor,
  output logic                          finished,
  output logic [rv32m_pkg::WORD_W-1:0]  quotient,
  output logic [rv32m_pkg::WORD_W-1:0]  remainder
);

  import rv32m_pkg::*;

  localparam int CNT_W = $clog2(WORD_W + 1);

  logic [WORD_W-1:0] quo_q;
  logic [WORD_W-1:0] rem_q;
  logic [WORD_W-1:0] dvs_q;
  logic [CNT_W-1:0]  count_q;
  logic              active_q;
  logic              finished_q;
  logic [WORD_W:0]   partial;
  logic [WORD_W:0]   diff;
  logic              take;

  // Shift the next dividend bit into the partial remainder.
  assign partial = {rem_q, quo_q[WORD_W-1]};
  assign diff    = partial - {1'b0, dvs_q};
  // No borrow means the divisor fits.
  assign take    = ~diff[WORD_W];

  // Datapath.
  // quo_q starts as the dividend and fills with quotient bits from the right.
  always_ff @(posedge CLK) begin
    if (start) begin
      quo_q <= dividend;
      rem_q <= '0;
      dvs_q <= divisor;
    end else if (active_q) begin
      rem_q <= take ? diff[WORD_W-1:0] : partial[WORD_W-1:0];
      quo_q <= {quo_q[WORD_W-2:0], take};
    end
  end

  // Iteration counter.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count_q    <= '0;
      active_q   <= 1'b0;
      finished_q <= 1'b0;
    end else begin
      finished_q <= 1'b0;
      if (start) begin
        count_q  <= CNT_W'(WORD_W);
        active_q <= 1'b1;
      end else if (active_q) begin
        count_q <= count_q - 1'b1;
        // Last iteration.
        if (count_q == CNT_W'(1)) begin
          active_q   <= 1'b0;
          finished_q <= 1'b1;
        end
      end
    end
  end

  assign finished  = finished_q;
  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

// File: divide_unit.sv
/*
 * Divide unit for DIV, DIVU, REM and REMU.
 * Divide-by-zero and signed overflow finish one edge after accept; other cases run
 * the restoring divider on magnitudes and fix the signs afterwards.
 */
`timescale 1ns/10ps

module divide_unit #(
  parameter int TAG_W = 5
) (
  input  logic                          CLK, nRST,
  input  logic                          start,
  input  rv32m_pkg::mext_op_t           op,
  input  logic [rv32m_pkg::WORD_W-1:0]  rs1_data,
  input  logic [rv32m_pkg::WORD_W-1:0]  rs2_data,
  input  logic [TAG_W-1:0]              tag,
  input  logic                          grant,
  output logic                          busy,
  output logic                          done,
  output logic [rv32m_pkg::WORD_W-1:0]  wdata,
  output logic [TAG_W-1:0]              wtag
);

  import rv32m_pkg::*;

  logic              signed_op, rem_op;
  logic              div_zero, overflow, special;
  logic [WORD_W-1:0] special_word;
  logic [WORD_W-1:0] rs1_abs, rs2_abs;
  logic [WORD_W-1:0] dvd_q, dvs_q;
  logic              q_neg_q, r_neg_q, rem_sel_q;
  logic              start_div_q, fast_q;
  logic              div_finished;
  logic [WORD_W-1:0] quotient, remainder;
  logic [WORD_W-1:0] q_fix, r_fix;

  divider u_divider (
    .CLK(CLK),
    .nRST(nRST),
    .start(start_div_q),
    .dividend(dvd_q),
    .divisor(dvs_q),
    .finished(div_finished),
    .quotient(quotient),
    .remainder(remainder)
  );

  assign signed_op = (op == DIV) || (op == REM);
  assign rem_op    = (op == REM) || (op == REMU);

  // Corner cases with fixed architectural results.
  assign div_zero = (rs2_data == '0);
  assign overflow = signed_op && (rs1_data == {1'b1, {(WORD_W-1){1'b0}}}) && (rs2_data == '1);
  assign special  = div_zero | overflow;
  // Zero divisor gives all ones or the dividend; overflow gives the dividend or zero.
  always_comb begin
    if (div_zero) begin
      special_word = rem_op ? rs1_data : '1;
    end else begin
      special_word = rem_op ? '0 : rs1_data;
    end
  end

  // Magnitudes for the unsigned divider.
  assign rs1_abs = (signed_op && rs1_data[WORD_W-1]) ? -rs1_data : rs1_data;
  assign rs2_abs = (signed_op && rs2_data[WORD_W-1]) ? -rs2_data : rs2_data;

  // Quotient is negative when the signs differ; remainder follows the dividend.
  assign q_fix = q_neg_q ? -quotient : quotient;
  assign r_fix = r_neg_q ? -remainder : remainder;

  always_ff @(posedge CLK) begin
    if (start) begin
      dvd_q     <= rs1_abs;
      dvs_q     <= rs2_abs;
      q_neg_q   <= signed_op & (rs1_data[WORD_W-1] ^ rs2_data[WORD_W-1]);
      r_neg_q   <= signed_op & rs1_data[WORD_W-1];
      rem_sel_q <= rem_op;
      wtag      <= tag;
    end
    // Early result is written on accept, divider result on the fix-up edge.
    if (start && special) begin
      wdata <= special_word;
    end else if (div_finished) begin
      wdata <= rem_sel_q ? r_fix : q_fix;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      start_div_q <= 1'b0;
      fast_q      <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
    end else begin
      start_div_q <= start & ~special;
      fast_q      <= start & special;
      if (start) begin
        busy <= 1'b1;
      end else if (grant) begin
        busy <= 1'b0;
      end
      if (fast_q || div_finished) begin
        done <= 1'b1;
      end else if (grant) begin
        done <= 1'b0;
      end
    end
  end

endmodule

// File: writeback_arbiter.sv
/*
 * Round-robin arbiter for the shared result port.
 * Picks between the multiply and divide units and grants only when the port is ready.
 * A result that is waiting keeps its selection until it is taken.
 */
`timescale 1ns/10ps

module writeback_arbiter #(
  parameter int TAG_W = 5
) (
  input  logic                          CLK, nRST,
  input  logic                          mul_done,
  input  logic [rv32m_pkg::WORD_W-1:0]  mul_wdata,
  input  logic [TAG_W-1:0]              mul_wtag,
  input  logic                          div_done,
  input  logic [rv32m_pkg::WORD_W-1:0]  div_wdata,
  input  logic [TAG_W-1:0]              div_wtag,
  input  logic                          result_ready,
  output logic                          mul_grant,
  output logic                          div_grant,
  output logic                          result_valid,
  output logic [rv32m_pkg::WORD_W-1:0]  result_data,
  output logic [TAG_W-1:0]              result_tag
);

  logic last_div_q;
  logic hold_q;
  logic held_div_q;
  logic pick_div;

  // A stalled result keeps its source.
  // Otherwise both pending means the unit not granted last wins.
  always_comb begin
    if (hold_q) begin
      pick_div = held_div_q;
    end else if (mul_done && div_done) begin
      pick_div = ~last_div_q;
    end else begin
      pick_div = div_done;
    end
  end

  assign result_valid = mul_done | div_done;
  assign result_data  = pick_div ? div_wdata : mul_wdata;
  assign result_tag   = pick_div ? div_wtag : mul_wtag;

  assign mul_grant = mul_done & ~pick_div & result_ready;
  assign div_grant = div_done & pick_div & result_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      last_div_q <= 1'b0;
      hold_q     <= 1'b0;
      held_div_q <= 1'b0;
    end else begin
      // Remember a result that was offered but not taken.
      hold_q     <= result_valid & ~result_ready;
      held_div_q <= pick_div;
      if (mul_grant || div_grant) begin
        last_div_q <= div_grant;
      end
    end
  end

endmodule

// File: rv32m_unit.sv
/*
 * Top level of the RV32M execution block.
 * Takes requests on a valid/ready port, steers them to the multiply or divide unit,
 * and returns tagged results through the round-robin writeback arbiter.
 */
`timescale 1ns/10ps

module rv32m_unit #(
  parameter int TAG_W      = 5,
  parameter int MUL_STAGES = 3
) (
  input  logic                          CLK, nRST,
  input  logic                          req_valid,
  input  rv32m_pkg::mext_op_t           req_op,
  input  logic [rv32m_pkg::WORD_W-1:0]  rs1_data,
  input  logic [rv32m_pkg::WORD_W-1:0]  rs2_data,
  input  logic [TAG_W-1:0]              req_tag,
  input  logic                          result_ready,
  output logic                          req_ready,
  output logic                          result_valid,
  output logic [rv32m_pkg::WORD_W-1:0]  result_data,
  output logic [TAG_W-1:0]              result_tag
);

  import rv32m_pkg::*;

  logic              to_div;
  logic              accept;
  logic              mul_start, div_start;
  logic              mul_busy, div_busy;
  logic              mul_done, div_done;
  logic              mul_grant, div_grant;
  logic [WORD_W-1:0] mul_wdata, div_wdata;
  logic [TAG_W-1:0]  mul_wtag, div_wtag;

  // Steering by the divide bit of the opcode.
  assign to_div    = is_div_op(req_op);
  assign req_ready = to_div ? ~div_busy : ~mul_busy;
  assign accept    = req_valid & req_ready;
  assign mul_start = accept & ~to_div;
  assign div_start = accept & to_div;

  multiply_unit #(
    .TAG_W(TAG_W),
    .MUL_STAGES(MUL_STAGES)
  ) u_multiply_unit (
    .CLK(CLK),
    .nRST(nRST),
    .start(mul_start),
    .op(req_op),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .tag(req_tag),
    .grant(mul_grant),
    .busy(mul_busy),
    .done(mul_done),
    .wdata(mul_wdata),
    .wtag(mul_wtag)
  );

  divide_unit #(
    .TAG_W(TAG_W)
  ) u_divide_unit (
    .CLK(CLK),
    .nRST(nRST),
    .start(div_start),
    .op(req_op),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .tag(req_tag),
    .grant(div_grant),
    .busy(div_busy),
    .done(div_done),
    .wdata(div_wdata),
    .wtag(div_wtag)
  );

  writeback_arbiter #(
    .TAG_W(TAG_W)
  ) u_writeback_arbiter (
    .CLK(CLK),
    .nRST(nRST),
    .mul_done(mul_done),
    .mul_wdata(mul_wdata),
    .mul_wtag(mul_wtag),
    .div_done(div_done),
    .div_wdata(div_wdata),
    .div_wtag(div_wtag),
    .result_ready(result_ready),
    .mul_grant(mul_grant),
    .div_grant(div_grant),
    .result_valid(result_valid),
    .result_data(result_data),
    .result_tag(result_tag)
  );

endmodule

// File: tb_rv32m_unit.sv
/*
 * Random-stimulus testbench for the RV32M execution block.
 * Requests are scored by tag against a reference model of the M-extension rules,
 * with optional random back-pressure on the result port.
 */
`timescale 1ns/10ps

module tb_rv32m_unit;

  import rv32m_pkg::*;

  localparam int TAG_W   = 5;
  localparam int TIMEOUT = 200;

  logic              CLK, nRST;
  logic              req_valid;
  mext_op_t          req_op;
  logic [WORD_W-1:0] rs1_data, rs2_data;
  logic [TAG_W-1:0]  req_tag;
  logic              result_ready;
  logic              req_ready;
  logic              result_valid;
  logic [WORD_W-1:0] result_data;
  logic [TAG_W-1:0]  result_tag;

  // Scoreboard, one slot per tag.
  logic [WORD_W-1:0] exp_word  [2**TAG_W];
  mext_op_t          exp_op    [2**TAG_W];
  logic              pending   [2**TAG_W];
  int                issue_seq [2**TAG_W];

  integer           seed;
  int               seq_count, in_flight;
  int               checks, errors, err_base, test_results, out_of_order;
  logic [TAG_W-1:0] next_tag;
  logic             stall_en;
  logic             aborted;
  logic             was_stalled;
  logic [WORD_W-1:0] held_data;
  logic [TAG_W-1:0]  held_tag;

  rv32m_unit #(
    .TAG_W(TAG_W),
    .MUL_STAGES(3)
  ) UUT (
    .CLK(CLK),
    .nRST(nRST),
    .req_valid(req_valid),
    .req_op(req_op),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .req_tag(req_tag),
    .result_ready(result_ready),
    .req_ready(req_ready),
    .result_valid(result_valid),
    .result_data(result_data),
    .result_tag(result_tag)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Architectural result of one M-extension operation.
  function automatic logic [WORD_W-1:0] ref_result(input mext_op_t op,
                                                   input logic [WORD_W-1:0] a,
                                                   input logic [WORD_W-1:0] b);
    logic [63:0]              sa, sb, ua, ub;
    logic [63:0]              p_ss, p_su, p_uu;
    logic signed [WORD_W-1:0] sa32, sb32, sq, sr;
    logic                     div_zero, overflow;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    // The low 64 bits of the extended products are exact.
    p_ss = sa * sb;
    p_su = sa * ub;
    p_uu = ua * ub;
    sa32 = a;
    sb32 = b;
    sq   = sa32 / sb32;
    sr   = sa32 % sb32;
    div_zero = (b == 32'h0);
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      MUL:     ref_result = p_uu[31:0];
      MULH:    ref_result = p_ss[63:32];
      MULHSU:  ref_result = p_su[63:32];
      MULHU:   ref_result = p_uu[63:32];
      DIV:     ref_result = div_zero ? {WORD_W{1'b1}} : (overflow ? a : sq);
      DIVU:    ref_result = div_zero ? {WORD_W{1'b1}} : a / b;
      REM:     ref_result = div_zero ? a : (overflow ? 32'h0 : sr);
      default: ref_result = div_zero ? a : a % b;
    endcase
  endfunction

  // Operand mix with the corner values of the ISA.
  function automatic logic [WORD_W-1:0] random_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[3:0])
      4'd0:    random_operand = 32'h0000_0000;
      4'd1:    random_operand = 32'h0000_0001;
      4'd2:    random_operand = 32'hffff_ffff;
      4'd3:    random_operand = 32'h8000_0000;
      4'd4:    random_operand = 32'h7fff_ffff;
      4'd5:    random_operand = r >> 24;
      4'd6:    random_operand = -(r >> 24);
      default: random_operand = $random(seed);
    endcase
  endfunction

  // Stops all further requests and counts the failure.
  task automatic abort_run(input string what, input int tag);
    errors++;
    aborted = 1'b1;
    $display("%s %0d at %0d ns", what, tag, $time);
  endtask

  task automatic check_mul_result(input mext_op_t op, input logic [WORD_W-1:0] actual,
                                  input logic [TAG_W-1:0] tag);
    checks++;
    if (actual !== exp_word[tag]) begin
      errors++;
      $display("Fail at %0d ns: %s tag %0d expected %h, got %h",
               $time, op.name(), tag, exp_word[tag], actual);
    end
  endtask

  task automatic check_div_result(input mext_op_t op, input logic [WORD_W-1:0] actual,
                                  input logic [TAG_W-1:0] tag);
    checks++;
    if (actual !== exp_word[tag]) begin
      errors++;
      $display("Fail at %0d ns: %s tag %0d expected %h, got %h",
               $time, op.name(), tag, exp_word[tag], actual);
    end
  endtask

  // Retire one transferred result against the scoreboard.
  task automatic take_result(input logic [TAG_W-1:0] tag, input logic [WORD_W-1:0] data);
    logic older;
    if (!pending[tag]) begin
      errors++;
      $display("Unexpected or duplicated result for tag %0d at %0d ns", tag, $time);
    end else begin
      older = 1'b0;
      for (int t = 0; t < 2**TAG_W; t++) begin
        if (pending[t] && issue_seq[t] < issue_seq[tag]) begin
          older = 1'b1;
        end
      end
      if (older) begin
        out_of_order++;
      end
      if (is_div_op(exp_op[tag])) begin
        check_div_result(exp_op[tag], data, tag);
      end else begin
        check_mul_result(exp_op[tag], data, tag);
      end
      pending[tag] = 1'b0;
      in_flight--;
      test_results++;
    end
  endtask

  // Result port monitor, sampling mid-cycle where outputs are settled.
  initial begin
    was_stalled = 1'b0;
    forever begin
      @(negedge CLK);
      if (stall_en) begin
        result_ready = $random(seed) & 1;
      end else begin
        result_ready = 1'b1;
      end
      #1;
      if (nRST === 1'b1 && was_stalled) begin
        if (result_valid !== 1'b1 || result_data !== held_data || result_tag !== held_tag) begin
          errors++;
          $display("Fail at %0d ns: stalled result changed, tag %0d -> %0d, data %h -> %h",
                   $time, held_tag, result_tag, held_data, result_data);
        end
      end
      if (nRST === 1'b1 && result_valid === 1'b1 && result_ready) begin
        take_result(result_tag, result_data);
      end
      was_stalled = (nRST === 1'b1) && (result_valid === 1'b1) && !result_ready;
      held_data   = result_data;
      held_tag    = result_tag;
    end
  end

  // Presents one request and waits until it is accepted.
  task automatic issue_op(input mext_op_t op, input logic [WORD_W-1:0] a,
                          input logic [WORD_W-1:0] b);
    int               waited;
    int               tries;
    logic [TAG_W-1:0] tag;
    if (!aborted) begin
      // First tag from next_tag on that is not in flight.
      tag   = next_tag;
      tries = 0;
      while (pending[tag] && tries < 2**TAG_W) begin
        tag = tag + 1'b1;
        tries++;
      end
      if (pending[tag]) begin
        abort_run("No free tag for a new request, last tried", tag);
      end else begin
        next_tag = tag + 1'b1;
        @(negedge CLK);
        req_valid = 1'b1;
        req_op    = op;
        rs1_data  = a;
        rs2_data  = b;
        req_tag   = tag;
        #1;
        waited = 0;
        while (!req_ready && waited < TIMEOUT) begin
          @(negedge CLK);
          #1;
          waited++;
        end
        if (!req_ready) begin
          abort_run("Timeout, request never accepted for tag", tag);
        end else begin
          // Transfer happens on the coming rising edge.
          exp_word[tag]  = ref_result(op, a, b);
          exp_op[tag]    = op;
          pending[tag]   = 1'b1;
          issue_seq[tag] = seq_count;
          seq_count++;
          in_flight++;
        end
      end
    end
  endtask

  task automatic wait_all_done();
    int waited;
    int missing;
    @(negedge CLK);
    req_valid = 1'b0;
    #1;
    waited = 0;
    while (!aborted && in_flight != 0 && waited < TIMEOUT) begin
      @(negedge CLK);
      #1;
      waited++;
    end
    if (!aborted && in_flight != 0) begin
      missing = 0;
      for (int t = 0; t < 2**TAG_W; t++) begin
        if (pending[t]) begin
          missing = t;
        end
      end
      abort_run("Timeout, no result for tag", missing);
    end
  endtask

  task automatic start_test();
    err_base     = errors;
    test_results = 0;
    out_of_order = 0;
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d results, %0d out of order, %0d errors",
             name, test_results, out_of_order, errors - err_base);
  endtask

  initial begin
    logic [31:0]       r;
    mext_op_t          op;
    logic [WORD_W-1:0] a, b;
    seed         = 32'h9c70_2a79;
    nRST         = 1'b0;
    req_valid    = 1'b0;
    req_op       = MUL;
    rs1_data     = '0;
    rs2_data     = '0;
    req_tag      = '0;
    result_ready = 1'b1;
    stall_en     = 1'b0;
    aborted      = 1'b0;
    next_tag     = '0;
    seq_count    = 0;
    in_flight    = 0;
    checks       = 0;
    errors       = 0;
    for (int t = 0; t < 2**TAG_W; t++) begin
      pending[t] = 1'b0;
    end
    repeat (4) @(negedge CLK);
    nRST = 1'b1;
    #1;

    // Idle state out of reset.
    start_test();
    checks++;
    if (req_ready !== 1'b1 || result_valid !== 1'b0) begin
      errors++;
      $display("Fail at %0d ns: after reset req_ready %b, result_valid %b",
               $time, req_ready, result_valid);
    end
    report_test("reset state");

    start_test();
    for (int i = 0; i < 200; i++) begin
      r  = $random(seed);
      op = mext_op_t'({1'b0, r[1:0]});
      a  = random_operand();
      b  = random_operand();
      issue_op(op, a, b);
    end
    wait_all_done();
    report_test("multiply family");

    start_test();
    for (int i = 0; i < 200; i++) begin
      r  = $random(seed);
      op = mext_op_t'({1'b1, r[1:0]});
      a  = random_operand();
      b  = random_operand();
      issue_op(op, a, b);
    end
    wait_all_done();
    report_test("divide family");

    // Zero divisor and signed overflow.
    start_test();
    issue_op(DIV, 32'h1234_5678, 32'h0);
    issue_op(DIVU, 32'hdead_beef, 32'h0);
    issue_op(REM, 32'h8765_4321, 32'h0);
    issue_op(REMU, 32'h0bad_f00d, 32'h0);
    issue_op(DIV, 32'h8000_0000, 32'hffff_ffff);
    issue_op(REM, 32'h8000_0000, 32'hffff_ffff);
    issue_op(DIVU, 32'h8000_0000, 32'hffff_ffff);
    wait_all_done();
    report_test("divide corner cases");

    // Back to back mix, results may overtake each other.
    start_test();
    for (int i = 0; i < 200; i++) begin
      r  = $random(seed);
      op = mext_op_t'(r[2:0]);
      a  = random_operand();
      b  = random_operand();
      issue_op(op, a, b);
    end
    wait_all_done();
    report_test("mixed back to back");

    start_test();
    stall_en = 1'b1;
    for (int i = 0; i < 150; i++) begin
      r  = $random(seed);
      op = mext_op_t'(r[2:0]);
      a  = random_operand();
      b  = random_operand();
      issue_op(op, a, b);
    end
    wait_all_done();
    stall_en = 1'b0;
    report_test("result back-pressure");

    $display("Totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: src.f
rv32m_pkg.sv
multiplier.sv
multiply_unit.sv
divider.sv
divide_unit.sv
writeback_arbiter.sv
rv32m_unit.sv
tb_rv32m_unit.sv
